//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

	localparam int XLEN     = 64;
	localparam int ILEN     = 32;
	localparam int NUM_REGS = 32;
	localparam int REG_AW   = 5;
	localparam int SHAMT_W  = 6;	// RV64 shift amount

	typedef logic [XLEN-1:0]	xlen_t;
	typedef logic [ILEN-1:0]	inst_t;
	typedef logic [REG_AW-1:0]	reg_addr_t;

	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b00_000_11,
		OPC_STORE  = 7'b01_000_11,
		OPC_BRANCH = 7'b11_000_11,
		OPC_JALR   = 7'b11_001_11,
		OPC_JAL    = 7'b11_011_11,
		OPC_OP_IMM = 7'b00_100_11,
		OPC_OP     = 7'b01_100_11,
		OPC_AUIPC  = 7'b00_101_11,
		OPC_LUI    = 7'b01_101_11
	} opcode_e;

	localparam logic [2:0] F3_W    = 3'b010;	// LW, SW
	localparam logic [2:0] F3_D    = 3'b011;	// LD, SD

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_ADD  = 3'b000;	// Also SUB
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;	// SRL and SRA
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;
	localparam logic [2:0] F3_JALR = 3'b000;

	localparam logic [6:0] FUNCT7_ALT = 7'b0100000;	// SUB, SRA

endpackage

//--- common/rv_core_pkg.sv
package rv_core_pkg;

	localparam rv_isa_pkg::xlen_t RESET_PC = 64'h0000_0000_8000_0000;
	localparam int MEM_WORDS = 1024;
	localparam int MEM_AW    = 10;

	typedef logic [MEM_AW-1:0]	mem_addr_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {
		CMP_EQ,
		CMP_NE,
		CMP_LT,
		CMP_GE,
		CMP_LTU,
		CMP_GEU
	} cmp_op_e;

	typedef enum logic       {SRC_A_RS1, SRC_A_PC} src_a_e;
	typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR} src_b_e;
	typedef enum logic       {WB_ALU, WB_MEM} wb_sel_e;

endpackage

//--- common/rv_decode_if.sv
`timescale 1ns/1ns

interface rv_decode_if;
	import rv_isa_pkg::*;
	import rv_core_pkg::*;

	reg_addr_t	rs1;
	reg_addr_t	rs2;
	reg_addr_t	rd;
	logic		rd_we;
	xlen_t		imm;	// Sign-extended for every format
	src_a_e		src_a;
	src_b_e		src_b;
	alu_op_e	alu_op;
	cmp_op_e	cmp_op;
	logic		mem_re;
	logic		mem_we;
	logic		mem_dword;
	wb_sel_e	wb_sel;

	modport ctrl (
		output rs1, rs2, rd, rd_we, imm,
		output src_a, src_b, alu_op, cmp_op,
		output mem_re, mem_we, mem_dword, wb_sel
	);

	modport rf  (input rs1, rs2, rd, rd_we, wb_sel);
	modport alu (input imm, src_a, src_b, alu_op, cmp_op);
	modport mem (input mem_re, mem_we, mem_dword);

endinterface

//--- logic/rv_control.sv
`timescale 1ns/1ns

module rv_control (
	input				CLK,
	input				RSTn,
	input				run_i,
	input  rv_isa_pkg::inst_t	inst_i,
	input  rv_isa_pkg::xlen_t	rs1_data_i,
	input				cmp_true_i,
	output rv_isa_pkg::xlen_t	pc_o,
	rv_decode_if.ctrl		dec
);
	import rv_isa_pkg::*;
	import rv_core_pkg::*;

	opcode_e	opcode;
	logic [2:0]	funct3;
	logic [6:0]	funct7;
	xlen_t		imm_i;
	xlen_t		imm_s;
	xlen_t		imm_b;
	xlen_t		imm_u;
	xlen_t		imm_j;
	logic		rd_we;
	logic		mem_re;
	logic		mem_we;
	logic		is_jal;
	logic		is_jalr;
	logic		is_branch;
	xlen_t		pc_q;
	xlen_t		pc_next;

	assign opcode = opcode_e'(inst_i[6:0]);
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
	assign imm_s = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b = {{51{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'h000};
	assign imm_j = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	assign dec.rs1 = inst_i[19:15];
	assign dec.rs2 = inst_i[24:20];
	assign dec.rd  = inst_i[11:7];

	// Nothing architectural happens while stopped
	assign dec.rd_we  = run_i && rd_we;
	assign dec.mem_re = run_i && mem_re;
	assign dec.mem_we = run_i && mem_we;

	always_comb begin
		rd_we         = 1'b0;
		mem_re        = 1'b0;
		mem_we        = 1'b0;
		is_jal        = 1'b0;
		is_jalr       = 1'b0;
		is_branch     = 1'b0;
		dec.imm       = '0;
		dec.src_a     = SRC_A_RS1;
		dec.src_b     = SRC_B_IMM;
		dec.alu_op    = ALU_ADD;
		dec.cmp_op    = CMP_EQ;
		dec.mem_dword = 1'b0;
		dec.wb_sel    = WB_ALU;
		case (opcode)
		OPC_LUI: begin
			rd_we      = 1'b1;
			dec.imm    = imm_u;
			dec.alu_op = ALU_PASS_B;
		end
		OPC_AUIPC: begin
			rd_we     = 1'b1;
			dec.imm   = imm_u;
			dec.src_a = SRC_A_PC;
		end
		OPC_JAL: begin
			rd_we     = 1'b1;
			is_jal    = 1'b1;
			dec.imm   = imm_j;
			dec.src_a = SRC_A_PC;	// Link is pc + 4
			dec.src_b = SRC_B_FOUR;
		end
		OPC_JALR: begin
			if (funct3 == F3_JALR) begin
				rd_we     = 1'b1;
				is_jalr   = 1'b1;
				dec.imm   = imm_i;
				dec.src_a = SRC_A_PC;
				dec.src_b = SRC_B_FOUR;
			end
		end
		OPC_BRANCH: begin
			dec.imm   = imm_b;
			is_branch = 1'b1;
			case (funct3)
			F3_BEQ:  dec.cmp_op = CMP_EQ;
			F3_BNE:  dec.cmp_op = CMP_NE;
			F3_BLT:  dec.cmp_op = CMP_LT;
			F3_BGE:  dec.cmp_op = CMP_GE;
			F3_BLTU: dec.cmp_op = CMP_LTU;
			F3_BGEU: dec.cmp_op = CMP_GEU;
			default: is_branch  = 1'b0;
			endcase
		end
		OPC_LOAD: begin
			if (funct3 == F3_W || funct3 == F3_D) begin
				rd_we         = 1'b1;
				mem_re        = 1'b1;
				dec.imm       = imm_i;
				dec.mem_dword = (funct3 == F3_D);
				dec.wb_sel    = WB_MEM;
			end
		end
		OPC_STORE: begin
			if (funct3 == F3_W || funct3 == F3_D) begin
				mem_we        = 1'b1;
				dec.imm       = imm_s;
				dec.mem_dword = (funct3 == F3_D);
			end
		end
		OPC_OP_IMM: begin
			rd_we   = 1'b1;
			dec.imm = imm_i;
			case (funct3)
			F3_ADD:  dec.alu_op = ALU_ADD;
			F3_SLT:  dec.alu_op = ALU_SLT;
			F3_SLTU: dec.alu_op = ALU_SLTU;
			F3_XOR:  dec.alu_op = ALU_XOR;
			F3_OR:   dec.alu_op = ALU_OR;
			F3_AND:  dec.alu_op = ALU_AND;
			F3_SLL: begin
				if (funct7[6:1] == 6'd0)
					dec.alu_op = ALU_SLL;
				else
					rd_we = 1'b0;
			end
			default: begin	// funct7[0] is shamt[5] here
				if (funct7[6:1] == 6'd0)
					dec.alu_op = ALU_SRL;
				else if (funct7[6:1] == FUNCT7_ALT[6:1])
					dec.alu_op = ALU_SRA;
				else
					rd_we = 1'b0;
			end
			endcase
		end
		OPC_OP: begin
			rd_we     = 1'b1;
			dec.src_b = SRC_B_RS2;
			case ({funct7, funct3})
			{7'd0, F3_ADD}:       dec.alu_op = ALU_ADD;
			{FUNCT7_ALT, F3_ADD}: dec.alu_op = ALU_SUB;
			{7'd0, F3_SLL}:       dec.alu_op = ALU_SLL;
			{7'd0, F3_SLT}:       dec.alu_op = ALU_SLT;
			{7'd0, F3_SLTU}:      dec.alu_op = ALU_SLTU;
			{7'd0, F3_XOR}:       dec.alu_op = ALU_XOR;
			{7'd0, F3_SR}:        dec.alu_op = ALU_SRL;
			{FUNCT7_ALT, F3_SR}:  dec.alu_op = ALU_SRA;
			{7'd0, F3_OR}:        dec.alu_op = ALU_OR;
			{7'd0, F3_AND}:       dec.alu_op = ALU_AND;
			default:              rd_we      = 1'b0;
			endcase
		end
		default: ;	// Unknown encodings retire as a no-op
		endcase
	end

	always_comb begin
		pc_next = pc_q + 64'd4;
		if (!run_i)
			pc_next = RESET_PC;
		else if (is_jalr)
			pc_next = (rs1_data_i + imm_i) & ~64'd1;
		else if (is_jal)
			pc_next = pc_q + imm_j;
		else if (is_branch && cmp_true_i)
			pc_next = pc_q + imm_b;
	end

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn)
			pc_q <= RESET_PC;
		else
			pc_q <= pc_next;
	end

	assign pc_o = pc_q;

	// Jump and branch targets stay on instruction boundaries
	a_pc_aligned: assert property (@(posedge CLK) disable iff (!RSTn)
		run_i |-> pc_q[1:0] == 2'b00);

endmodule

//--- logic/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile (
	input				CLK,
	input				RSTn,
	rv_decode_if.rf			dec,
	input  rv_isa_pkg::xlen_t	alu_result_i,
	input  rv_isa_pkg::xlen_t	load_data_i,
	output rv_isa_pkg::xlen_t	rs1_data_o,
	output rv_isa_pkg::xlen_t	rs2_data_o,
	output logic			wb_we_o,
	output rv_isa_pkg::reg_addr_t	wb_addr_o,
	output rv_isa_pkg::xlen_t	wb_data_o
);
	import rv_isa_pkg::*;
	import rv_core_pkg::*;

	xlen_t	regs [NUM_REGS];

	assign rs1_data_o = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
	assign rs2_data_o = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

	assign wb_we_o   = dec.rd_we && (dec.rd != '0);	// x0 is never written
	assign wb_addr_o = dec.rd;
	assign wb_data_o = (dec.wb_sel == WB_MEM) ? load_data_i : alu_result_i;

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb_we_o) begin
			regs[wb_addr_o] <= wb_data_o;
		end
	end

	// Write-back lands in the addressed register
	a_wb_commit: assert property (@(posedge CLK) disable iff (!RSTn)
		wb_we_o |=> regs[$past(wb_addr_o)] == $past(wb_data_o));

endmodule

//--- logic/rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
	rv_decode_if.alu		dec,
	input  rv_isa_pkg::xlen_t	pc_i,
	input  rv_isa_pkg::xlen_t	rs1_data_i,
	input  rv_isa_pkg::xlen_t	rs2_data_i,
	output rv_isa_pkg::xlen_t	alu_result_o,
	output logic			cmp_true_o
);
	import rv_isa_pkg::*;
	import rv_core_pkg::*;

	xlen_t			op_a;
	xlen_t			op_b;
	logic [SHAMT_W-1:0]	shamt;

	assign op_a = (dec.src_a == SRC_A_PC) ? pc_i : rs1_data_i;

	always_comb begin
		case (dec.src_b)
		SRC_B_RS2:  op_b = rs2_data_i;
		SRC_B_FOUR: op_b = 64'd4;
		default:    op_b = dec.imm;
		endcase
	end

	assign shamt = op_b[SHAMT_W-1:0];

	always_comb begin
		case (dec.alu_op)
		ALU_ADD:  alu_result_o = op_a + op_b;
		ALU_SUB:  alu_result_o = op_a - op_b;
		ALU_SLL:  alu_result_o = op_a << shamt;
		ALU_SLT:  alu_result_o = {{XLEN-1{1'b0}}, $signed(op_a) < $signed(op_b)};
		ALU_SLTU: alu_result_o = {{XLEN-1{1'b0}}, op_a < op_b};
		ALU_XOR:  alu_result_o = op_a ^ op_b;
		ALU_SRL:  alu_result_o = op_a >> shamt;
		ALU_SRA:  alu_result_o = $signed(op_a) >>> shamt;
		ALU_OR:   alu_result_o = op_a | op_b;
		ALU_AND:  alu_result_o = op_a & op_b;
		default:  alu_result_o = op_b;	// LUI
		endcase
	end

	// Branch condition, independent of the operand muxes
	always_comb begin
		case (dec.cmp_op)
		CMP_EQ:  cmp_true_o = (rs1_data_i == rs2_data_i);
		CMP_NE:  cmp_true_o = (rs1_data_i != rs2_data_i);
		CMP_LT:  cmp_true_o = ($signed(rs1_data_i) < $signed(rs2_data_i));
		CMP_GE:  cmp_true_o = ($signed(rs1_data_i) >= $signed(rs2_data_i));
		CMP_LTU: cmp_true_o = (rs1_data_i < rs2_data_i);
		CMP_GEU: cmp_true_o = (rs1_data_i >= rs2_data_i);
		default: cmp_true_o = 1'b0;
		endcase
	end

endmodule

//--- logic/rv_memory.sv
`timescale 1ns/1ns

module rv_memory (
	input				CLK,
	input				RSTn,
	rv_decode_if.mem		dec,
	input  rv_isa_pkg::xlen_t	pc_i,
	input  rv_isa_pkg::xlen_t	addr_i,
	input  rv_isa_pkg::xlen_t	store_data_i,
	input				load_we_i,
	input  rv_core_pkg::mem_addr_t	load_addr_i,
	input  logic [31:0]		load_data_i,
	output rv_isa_pkg::inst_t	inst_o,
	output rv_isa_pkg::xlen_t	load_data_o
);
	import rv_core_pkg::*;

	logic [31:0]	ram [MEM_WORDS];
	mem_addr_t	fetch_idx;
	mem_addr_t	data_lo;
	mem_addr_t	data_hi;
	logic [31:0]	word_lo;

	assign fetch_idx = pc_i[MEM_AW+1:2];
	assign data_lo   = addr_i[MEM_AW+1:2];
	assign data_hi   = data_lo + 1'b1;	// Upper half of a doubleword
	assign word_lo   = ram[data_lo];

	assign inst_o = ram[fetch_idx];

	always_comb begin
		if (!dec.mem_re)
			load_data_o = '0;
		else if (dec.mem_dword)
			load_data_o = {ram[data_hi], word_lo};
		else
			load_data_o = {{32{word_lo[31]}}, word_lo};
	end

	always_ff @(posedge CLK) begin
		if (load_we_i) begin
			ram[load_addr_i] <= load_data_i;
		end else if (dec.mem_we) begin
			ram[data_lo] <= store_data_i[31:0];
			if (dec.mem_dword)
				ram[data_hi] <= store_data_i[63:32];
		end
	end

	a_aligned: assert property (@(posedge CLK) disable iff (!RSTn)
		(dec.mem_re || dec.mem_we) |->
			(dec.mem_dword ? addr_i[2:0] == 3'd0 : addr_i[1:0] == 2'd0));

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ns

module rv_core (
	input				CLK,
	input				RSTn,
	input				run_i,
	input				load_we_i,
	input  rv_core_pkg::mem_addr_t	load_addr_i,
	input  logic [31:0]		load_data_i,
	output rv_isa_pkg::xlen_t	pc_o,
	output logic			wb_we_o,
	output rv_isa_pkg::reg_addr_t	wb_addr_o,
	output rv_isa_pkg::xlen_t	wb_data_o
);
	import rv_isa_pkg::*;

	inst_t	inst;
	xlen_t	rs1_data;
	xlen_t	rs2_data;
	xlen_t	alu_result;	// Data address or link value
	xlen_t	load_data;
	logic	cmp_true;

	rv_decode_if	dec ();

	rv_control i_control (
		.CLK		(CLK),
		.RSTn		(RSTn),
		.run_i		(run_i),
		.inst_i		(inst),
		.rs1_data_i	(rs1_data),
		.cmp_true_i	(cmp_true),
		.pc_o		(pc_o),
		.dec		(dec.ctrl)
	);

	rv_regfile i_regfile (
		.CLK		(CLK),
		.RSTn		(RSTn),
		.dec		(dec.rf),
		.alu_result_i	(alu_result),
		.load_data_i	(load_data),
		.rs1_data_o	(rs1_data),
		.rs2_data_o	(rs2_data),
		.wb_we_o	(wb_we_o),
		.wb_addr_o	(wb_addr_o),
		.wb_data_o	(wb_data_o)
	);

	rv_alu i_alu (
		.dec		(dec.alu),
		.pc_i		(pc_o),
		.rs1_data_i	(rs1_data),
		.rs2_data_i	(rs2_data),
		.alu_result_o	(alu_result),
		.cmp_true_o	(cmp_true)
	);

	rv_memory i_memory (
		.CLK		(CLK),
		.RSTn		(RSTn),
		.dec		(dec.mem),
		.pc_i		(pc_o),
		.addr_i		(alu_result),
		.store_data_i	(rs2_data),
		.load_we_i	(load_we_i),
		.load_addr_i	(load_addr_i),
		.load_data_i	(load_data_i),
		.inst_o		(inst),
		.load_data_o	(load_data)
	);

endmodule

//--- dv/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic inst_t itype(opcode_e op, logic [2:0] f3, reg_addr_t rd,
		reg_addr_t rs1, logic [11:0] imm);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic inst_t rtype(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
		reg_addr_t rs1, reg_addr_t rs2);
	return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic inst_t stype(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
		logic [11:0] imm);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

function automatic inst_t btype(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
		logic [12:0] off);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic inst_t utype(opcode_e op, reg_addr_t rd, logic [19:0] imm);
	return {imm, rd, op};
endfunction

function automatic inst_t jtype(reg_addr_t rd, logic [20:0] off);
	return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

function automatic xlen_t sext12(logic [11:0] v);
	return {{52{v[11]}}, v};
endfunction

function automatic xlen_t sext32(logic [31:0] v);
	return {{32{v[31]}}, v};
endfunction

function automatic inst_t marker_inst();
	return itype(OPC_OP_IMM, F3_ADD, 9, 0, 12'h7ff);	// Must never retire
endfunction

function automatic void clear_program();
	prog_n = 0;
	exp_n  = 0;
endfunction

function automatic void put_inst(inst_t inst);
	prog[prog_n] = inst;
	prog_n++;
endfunction

function automatic void add_expect(reg_addr_t rd, xlen_t val);
	exp_rd[exp_n]  = rd;
	exp_val[exp_n] = val;
	exp_n++;
endfunction

function automatic xlen_t next_pc();
	return RESET_PC + xlen_t'(4 * prog_n);
endfunction

function automatic void halt_loop();
	put_inst(jtype(0, 21'd0));	// JAL x0 to itself
endfunction

task automatic imm_arith_program();
	logic [11:0] i1;
	logic [11:0] i2;
	logic [11:0] i3;
	xlen_t v1;
	xlen_t v2;
	xlen_t v5;
	xlen_t pc_a;
	clear_program();
	i1 = rand_imm12();
	i2 = rand_imm12();
	i3 = rand_imm12();
	v1 = sext12(i1);
	v2 = v1 + sext12(i2);
	v5 = 64'hffff_ffff_8012_3000;
	put_inst(itype(OPC_OP_IMM, F3_ADD, 1, 0, i1));
	add_expect(1, v1);
	put_inst(itype(OPC_OP_IMM, F3_ADD, 2, 1, i2));
	add_expect(2, v2);
	put_inst(itype(OPC_OP_IMM, F3_SLT, 3, 1, i3));
	add_expect(3, xlen_t'($signed(v1) < $signed(sext12(i3))));
	put_inst(itype(OPC_OP_IMM, F3_XOR, 4, 2, 12'h5a5));
	add_expect(4, v2 ^ sext12(12'h5a5));
	put_inst(utype(OPC_LUI, 5, 20'h80123));
	add_expect(5, v5);
	put_inst(itype(OPC_OP_IMM, F3_SR, 6, 5, {6'b010000, 6'd36}));	// SRAI
	add_expect(6, $signed(v5) >>> 36);
	pc_a = next_pc();
	put_inst(utype(OPC_AUIPC, 7, 20'hfffff));
	add_expect(7, pc_a + 64'hffff_ffff_ffff_f000);
	halt_loop();
endtask

task automatic reg_arith_program();
	xlen_t a;
	xlen_t b;
	xlen_t s;
	clear_program();
	a = 64'hffff_ffff_ffff_fff9;
	b = 64'h1234_5678;
	s = 64'h7e5;	// Low 6 bits give 37
	put_inst(itype(OPC_OP_IMM, F3_ADD, 10, 0, 12'hff9));
	add_expect(10, a);
	put_inst(utype(OPC_LUI, 11, 20'h12345));
	add_expect(11, 64'h1234_5000);
	put_inst(itype(OPC_OP_IMM, F3_ADD, 11, 11, 12'h678));
	add_expect(11, b);
	put_inst(itype(OPC_OP_IMM, F3_ADD, 12, 0, 12'h7e5));
	add_expect(12, s);
	put_inst(rtype(7'd0, F3_ADD, 13, 10, 11));
	add_expect(13, a + b);
	put_inst(rtype(FUNCT7_ALT, F3_ADD, 14, 10, 11));
	add_expect(14, a - b);
	put_inst(rtype(7'd0, F3_SLL, 15, 11, 12));
	add_expect(15, b << s[5:0]);
	put_inst(rtype(7'd0, F3_SLT, 16, 10, 11));
	add_expect(16, xlen_t'($signed(a) < $signed(b)));
	put_inst(rtype(7'd0, F3_SLTU, 17, 10, 11));
	add_expect(17, xlen_t'(a < b));
	put_inst(rtype(FUNCT7_ALT, F3_SR, 18, 14, 12));
	add_expect(18, $signed(a - b) >>> s[5:0]);
	put_inst(rtype(7'd0, F3_OR, 19, 10, 11));
	add_expect(19, a | b);
	put_inst(rtype(7'd0, F3_AND, 20, 10, 11));
	add_expect(20, a & b);
	halt_loop();
endtask

task automatic memory_program();
	xlen_t v2;
	xlen_t v3;
	clear_program();
	v2 = 64'hffff_ffff_fedc_b789;
	v3 = (v2 << 28) + 64'h234;
	put_inst(utype(OPC_LUI, 1, 20'h80000));
	add_expect(1, 64'hffff_ffff_8000_0000);
	put_inst(itype(OPC_OP_IMM, F3_ADD, 1, 1, 12'h400));	// Data area, clear of code
	add_expect(1, 64'hffff_ffff_8000_0400);
	put_inst(utype(OPC_LUI, 2, 20'hfedcb));
	add_expect(2, 64'hffff_ffff_fedc_b000);
	put_inst(itype(OPC_OP_IMM, F3_ADD, 2, 2, 12'h789));
	add_expect(2, v2);
	put_inst(itype(OPC_OP_IMM, F3_SLL, 3, 2, 12'd28));
	add_expect(3, v2 << 28);
	put_inst(itype(OPC_OP_IMM, F3_ADD, 3, 3, 12'h234));
	add_expect(3, v3);
	put_inst(stype(F3_D, 1, 3, 12'd8));
	put_inst(itype(OPC_LOAD, F3_D, 4, 1, 12'd8));
	add_expect(4, v3);
	put_inst(stype(F3_W, 1, 2, 12'd16));
	put_inst(itype(OPC_LOAD, F3_W, 5, 1, 12'd16));
	add_expect(5, sext32(v2[31:0]));
	put_inst(stype(F3_W, 1, 3, 12'd24));
	put_inst(itype(OPC_LOAD, F3_W, 6, 1, 12'd24));
	add_expect(6, sext32(v3[31:0]));
	put_inst(itype(OPC_LOAD, F3_W, 7, 1, 12'd12));	// Upper word of the SD
	add_expect(7, sext32(v3[63:32]));
	halt_loop();
endtask

// Taken branch skips a marker, not-taken branch runs an ADDI to x10
task automatic branch_pair(logic [2:0] f3, reg_addr_t t1, reg_addr_t t2,
		reg_addr_t n1, reg_addr_t n2, logic [11:0] k);
	put_inst(btype(f3, t1, t2, 13'd8));
	put_inst(marker_inst());
	put_inst(btype(f3, n1, n2, 13'd8));
	put_inst(itype(OPC_OP_IMM, F3_ADD, 10, 0, k));
	add_expect(10, sext12(k));
endtask

task automatic control_program();
	xlen_t pc_a;
	clear_program();
	put_inst(itype(OPC_OP_IMM, F3_ADD, 1, 0, 12'd5));
	add_expect(1, 64'd5);
	put_inst(itype(OPC_OP_IMM, F3_ADD, 2, 0, 12'hffd));
	add_expect(2, 64'hffff_ffff_ffff_fffd);
	put_inst(itype(OPC_OP_IMM, F3_ADD, 3, 0, 12'd5));
	add_expect(3, 64'd5);
	branch_pair(F3_BEQ, 1, 3, 1, 2, 12'd1);
	branch_pair(F3_BNE, 1, 2, 1, 3, 12'd2);
	branch_pair(F3_BLT, 2, 1, 1, 2, 12'd3);
	branch_pair(F3_BGE, 1, 3, 2, 1, 12'd4);
	branch_pair(F3_BLTU, 1, 2, 2, 1, 12'd5);
	branch_pair(F3_BGEU, 2, 1, 1, 2, 12'd6);
	pc_a = next_pc();
	put_inst(jtype(5, 21'd8));
	add_expect(5, pc_a + 64'd4);
	put_inst(marker_inst());
	pc_a = next_pc();
	put_inst(utype(OPC_AUIPC, 6, 20'd0));
	add_expect(6, pc_a);
	put_inst(itype(OPC_JALR, F3_JALR, 7, 6, 12'd17));	// Bit 0 of target dropped
	add_expect(7, pc_a + 64'd8);
	put_inst(marker_inst());
	put_inst(marker_inst());
	put_inst(itype(OPC_OP_IMM, F3_ADD, 8, 0, 12'h055));
	add_expect(8, 64'h55);
	halt_loop();
endtask

task automatic zero_reg_program();
	clear_program();
	put_inst(itype(OPC_OP_IMM, F3_ADD, 0, 0, 12'h123));
	put_inst(itype(OPC_OP_IMM, F3_ADD, 1, 0, 12'h345));
	add_expect(1, 64'h345);
	put_inst(rtype(7'd0, F3_ADD, 0, 1, 1));
	put_inst(rtype(7'd0, F3_ADD, 2, 1, 0));
	add_expect(2, 64'h345);
	put_inst(rtype(7'd0, F3_ADD, 3, 0, 1));
	add_expect(3, 64'h345);
	halt_loop();
endtask

`endif

//--- dv/tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core;
	import rv_isa_pkg::*;
	import rv_core_pkg::*;

	localparam int RUN_CYCLES  = 48;
	localparam int NUM_TESTS   = 5;	// Tests that run a program
	localparam int WATCHDOG_NS = 2 * NUM_TESTS * RUN_CYCLES * 4;

	logic		CLK;
	logic		RSTn;
	logic		run;
	logic		load_we;
	mem_addr_t	load_addr;
	logic [31:0]	load_data;
	xlen_t		pc;
	logic		wb_we;
	reg_addr_t	wb_addr;
	xlen_t		wb_data;

	inst_t		prog [64];
	int		prog_n;
	reg_addr_t	exp_rd [64];
	xlen_t		exp_val [64];
	int		exp_n;

	logic [31:0]	lfsr;
	string		test_name;
	int		err_total = 0;
	int		tests = 0;
	int		fails = 0;
	int		wb_count = 0;
	int		wb_base = 0;
	int		cur_idx;
	reg_addr_t	cur_rd;
	xlen_t		cur_val;

	rv_core i_dut (
		.CLK		(CLK),
		.RSTn		(RSTn),
		.run_i		(run),
		.load_we_i	(load_we),
		.load_addr_i	(load_addr),
		.load_data_i	(load_data),
		.pc_o		(pc),
		.wb_we_o	(wb_we),
		.wb_addr_o	(wb_addr),
		.wb_data_o	(wb_data)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [11:0] rand_imm12();
		logic [11:0] r;
		r = '0;
		for (int i = 0; i < 12; i++) begin
			lfsr = lfsr_step(lfsr);	// One step per bit
			r = {r[10:0], lfsr[0]};
		end
		return r;
	endfunction

	`include "tb_programs.svh"

	// Position in the expected write-back table
	assign cur_idx = wb_count - wb_base;
	assign cur_rd  = exp_rd[cur_idx[5:0]];
	assign cur_val = exp_val[cur_idx[5:0]];

	always @(posedge CLK)
		if (RSTn && wb_we)
			wb_count <= wb_count + 1;

	a_wb_in_table: assert property (@(posedge CLK) disable iff (!RSTn)
		wb_we |-> (cur_idx < exp_n))
	else begin
		err_total++;
		$display("%s: register write to x%0d beyond the %0d expected writes",
			test_name, $sampled(wb_addr), exp_n);
	end

	a_wb_value: assert property (@(posedge CLK) disable iff (!RSTn)
		(wb_we && cur_idx < exp_n) |-> (wb_addr == cur_rd && wb_data == cur_val))
	else begin
		err_total++;
		$display("error %s: write %0d expected x%0d=%h actual x%0d=%h", test_name,
			$sampled(cur_idx), $sampled(cur_rd), $sampled(cur_val),
			$sampled(wb_addr), $sampled(wb_data));
	end

	a_idle_quiet: assert property (@(posedge CLK) disable iff (!RSTn)
		!run |-> !wb_we)
	else begin
		err_total++;
		$display("%s: register write while the core was stopped", test_name);
	end

	task automatic report_test(input int err_start);
		tests++;
		if (err_total == err_start) begin
			$display("test %s pass", test_name);
		end else begin
			fails++;
			$display("test %s failed with %0d errors", test_name, err_total - err_start);
		end
	endtask

	task automatic check_reset_idle();
		int err_start;
		err_start = err_total;
		test_name = "reset";
		repeat (3) begin
			@(negedge CLK);
			a_pc_reset: assert (pc == RESET_PC) else begin
				err_total++;
				$display("error reset: pc expected %h actual %h", RESET_PC, pc);
			end
			a_wb_reset: assert (!wb_we) else begin
				err_total++;
				$display("reset: register write enable high after reset");
			end
		end
		report_test(err_start);
	endtask

	task automatic run_program(input string name);
		int err_start;
		err_start = err_total;
		test_name = name;
		for (int i = 0; i < prog_n; i++) begin
			@(negedge CLK);
			load_we   = 1'b1;
			load_addr = RESET_PC[MEM_AW+1:2] + mem_addr_t'(i);
			load_data = prog[i];
		end
		@(negedge CLK);
		load_we = 1'b0;
		wb_base = wb_count;
		run     = 1'b1;
		repeat (RUN_CYCLES) @(negedge CLK);
		run = 1'b0;
		@(negedge CLK);
		a_write_count: assert (cur_idx == exp_n) else begin
			err_total++;
			$display("%s: %0d register writes seen where %0d were expected",
				test_name, cur_idx, exp_n);
		end
		report_test(err_start);
	endtask

	initial begin
		RSTn      = 1'b0;
		run       = 1'b0;
		load_we   = 1'b0;
		load_addr = '0;
		load_data = '0;
		lfsr      = 32'h6471;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RSTn = 1'b1;

		check_reset_idle();
		imm_arith_program();
		run_program("imm_arith");
		reg_arith_program();
		run_program("reg_arith");
		memory_program();
		run_program("memory");
		control_program();
		run_program("control_flow");
		zero_reg_program();
		run_program("x0");

		$display("%0d tests, %0d failed, %0d errors", tests, fails, err_total);
		if (fails == 0 && err_total == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- files.f
+incdir+dv
common/rv_isa_pkg.sv
common/rv_core_pkg.sv
common/rv_decode_if.sv
logic/rv_control.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_memory.sv
logic/rv_core.sv
dv/tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_rv_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, pass if the log holds STATUS: PASS"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
